// File: core_types_pkg.sv
/* core types package
   geometry of the BRAM array and the vector types for its index, data and byte enables. */

package core_types_pkg;

	// number of entries in the array.
	localparam int OUTER_WIDTH = 32;

	// bits held by one entry.
	localparam int INNER_WIDTH = 32;

	// bits needed to select one entry.
	localparam int INDEX_WIDTH = $clog2(OUTER_WIDTH);

	// width of one write lane, and how many lanes make up an entry.
	localparam int BYTE_WIDTH = 8;
	localparam int BYTE_LANES = INNER_WIDTH / BYTE_WIDTH;

	// an entry index.
	typedef logic [INDEX_WIDTH-1:0] bram_index_t;

	// one full entry as stored in the array.
	typedef logic [INNER_WIDTH-1:0] bram_data_t;

	// bit n enables byte lane n of a write, counting up from the lowest byte.
	typedef logic [BYTE_LANES-1:0] bram_byte_en_t;

endpackage

// File: bram_port_pkg.sv
/* bram port package
   request formats for the two read ports and the byte-enabled write port. */

package bram_port_pkg;

	import core_types_pkg::*;

	// a read request.
	// the port reads whenever ren is high. there is no strobe and no
	// handshake, so a request that is held high reads again each cycle.
	typedef struct packed {
		logic ren;
		bram_index_t rindex;
	} bram_rreq_t;

	// a write request.
	// the write takes place when any bit of wen_byte is set. only the
	// enabled lanes of the entry at windex take the new bytes from wdata,
	// and the other lanes keep their old contents.
	typedef struct packed {
		bram_byte_en_t wen_byte;
		bram_index_t windex;
		bram_data_t wdata;
	} bram_wreq_t;

endpackage

// File: bram_2rport_1wport.sv
/* dual-read single-write block RAM
   two synchronous read ports with one cycle of latency and one write port with byte enables. */

module bram_2rport_1wport (
	input logic CLK,
	input logic nRST,

	input bram_port_pkg::bram_rreq_t port0_rreq,
	input bram_port_pkg::bram_rreq_t port1_rreq,
	input bram_port_pkg::bram_wreq_t wreq,

	output core_types_pkg::bram_data_t port0_rdata,
	output core_types_pkg::bram_data_t port1_rdata
);

	import core_types_pkg::*;

	// merges new bytes into an old word, lane by lane.
	// a lane takes the new byte only when its enable is set.
	function automatic bram_data_t merge_lanes(
		input bram_data_t old_word,
		input bram_data_t new_word,
		input bram_byte_en_t lane_en
	);
		bram_data_t merged;
		merged = old_word;
		for (int lane = 0; lane < BYTE_LANES; lane++) begin
			if (lane_en[lane]) begin
				merged[lane*BYTE_WIDTH +: BYTE_WIDTH] =
					new_word[lane*BYTE_WIDTH +: BYTE_WIDTH];
			end
		end
		return merged;
	endfunction

	// the storage itself.
	bram_data_t mem [OUTER_WIDTH];

	// the word that the current write would leave behind at windex.
	bram_data_t write_word;

	// high when at least one byte lane of the write is enabled.
	logic write_active;

	assign write_active = |wreq.wen_byte;

	// the merge needs the old word, so a partial write is a read-modify-write
	// of the addressed entry within the same cycle.
	always_comb begin
		write_word = merge_lanes(mem[wreq.windex], wreq.wdata, wreq.wen_byte);
	end

	// write port.
	// reset clears every entry. after that, each write replaces the enabled
	// lanes of the entry at windex.
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int i = 0; i < OUTER_WIDTH; i++) begin
				mem[i] <= '0;
			end
		end
		else if (write_active) begin
			mem[wreq.windex] <= write_word;
		end
	end

	// read ports.
	// both ports sample the array on the same edge that the write lands, so a
	// read of the index being written returns the word from before the write.
	// a port whose ren is low keeps the last word it read.
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			port0_rdata <= '0;
			port1_rdata <= '0;
		end
		else begin
			if (port0_rreq.ren) begin
				port0_rdata <= mem[port0_rreq.rindex];
			end
			if (port1_rreq.ren) begin
				port1_rdata <= mem[port1_rreq.rindex];
			end
		end
	end

endmodule

// File: bram_2rport_1wport_wrapper.sv
/* BRAM timing wrapper
   registers every request into the dual-read RAM and both read words out of it. */

module bram_2rport_1wport_wrapper (
	input logic CLK,
	input logic nRST,

	input bram_port_pkg::bram_rreq_t next_port0_rreq,
	input bram_port_pkg::bram_rreq_t next_port1_rreq,
	input bram_port_pkg::bram_wreq_t next_wreq,

	output core_types_pkg::bram_data_t last_port0_rdata,
	output core_types_pkg::bram_data_t last_port1_rdata
);

	import core_types_pkg::*;
	import bram_port_pkg::*;

	// requests after the input stage, as seen by the array.
	bram_rreq_t port0_rreq;
	bram_rreq_t port1_rreq;
	bram_wreq_t wreq;

	// read words straight from the array, before the output stage.
	bram_data_t port0_rdata;
	bram_data_t port1_rdata;

	bram_2rport_1wport wrapped_bram (
		.CLK(CLK),
		.nRST(nRST),
		.port0_rreq(port0_rreq),
		.port1_rreq(port1_rreq),
		.wreq(wreq),
		.port0_rdata(port0_rdata),
		.port1_rdata(port1_rdata)
	);

	// input stage.
	// clearing the requests on reset leaves every enable low, so the array
	// sees neither a read nor a write until the first real request arrives.
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			port0_rreq <= '0;
			port1_rreq <= '0;
			wreq <= '0;
		end
		else begin
			port0_rreq <= next_port0_rreq;
			port1_rreq <= next_port1_rreq;
			wreq <= next_wreq;
		end
	end

	// output stage.
	// together with the input stage and the array's own read register this
	// gives a fixed latency of three edges from request to last_portN_rdata.
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			last_port0_rdata <= '0;
			last_port1_rdata <= '0;
		end
		else begin
			last_port0_rdata <= port0_rdata;
			last_port1_rdata <= port1_rdata;
		end
	end

endmodule

// File: tb_bram_2rport_1wport.sv
/* testbench for the BRAM timing wrapper
   replays the pattern file through the wrapper and checks both read ports. */

module tb_bram_2rport_1wport;

	import core_types_pkg::*;
	import bram_port_pkg::*;

	localparam string PATTERN_FILE = "bram_patterns.txt";

	// each pattern line holds nine hex fields.
	localparam int FIELDS = 9;
	localparam int MAX_LINES = 256;

	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 3;
	localparam int TIMEOUT_MARGIN = 10;

	// edges from driving a request to its word on last_portN_rdata.
	localparam int PIPE_DEPTH = 3;

	// what one driven line expects to see once its reads come out.
	typedef struct packed {
		logic ren0;
		bram_data_t exp0;
		logic ren1;
		bram_data_t exp1;
	} expected_t;

	logic CLK;
	logic nRST;

	bram_rreq_t next_port0_rreq;
	bram_rreq_t next_port1_rreq;
	bram_wreq_t next_wreq;

	bram_data_t last_port0_rdata;
	bram_data_t last_port1_rdata;

	logic [31:0] pattern_mem [FIELDS*MAX_LINES];
	expected_t expect_queue [$];

	int line_count;
	int error_count;
	int check_count;
	int cycle_count;
	int cycle_limit;

	bram_2rport_1wport_wrapper UUT (
		.CLK(CLK),
		.nRST(nRST),
		.next_port0_rreq(next_port0_rreq),
		.next_port1_rreq(next_port1_rreq),
		.next_wreq(next_wreq),
		.last_port0_rdata(last_port0_rdata),
		.last_port1_rdata(last_port1_rdata)
	);

	always #HALF_PERIOD CLK = ~CLK;

	// prints the closing counts and the verdict, then ends the run.
	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end
		else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	task automatic compare_word(
		input string name,
		input bram_data_t actual,
		input bram_data_t expected
	);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// the fill marks every slot, so the first line slot whose read enable is
	// not 0 or 1 is where the file ended.
	task automatic load_patterns();
		int base;
		for (int k = 0; k < FIELDS*MAX_LINES; k++) begin
			pattern_mem[k] = 32'hf000_0000 | 32'(k);
		end
		$readmemh(PATTERN_FILE, pattern_mem);
		line_count = 0;
		while (line_count < MAX_LINES && pattern_mem[line_count*FIELDS] <= 1) begin
			base = line_count * FIELDS;
			if (pattern_mem[base + 1] >= OUTER_WIDTH || pattern_mem[base + 3] >= OUTER_WIDTH ||
				pattern_mem[base + 5] >= OUTER_WIDTH || pattern_mem[base + 2] > 1 ||
				pattern_mem[base + 4] >= (1 << BYTE_LANES)) begin
				$display("pattern line %0d has a field that does not fit its port", line_count);
				error_count++;
			end
			line_count++;
		end
	endtask

	task automatic apply_request(
		input bram_rreq_t rreq0,
		input bram_rreq_t rreq1,
		input bram_wreq_t wreq,
		input bram_data_t exp0,
		input bram_data_t exp1
	);
		expected_t entry;
		next_port0_rreq = rreq0;
		next_port1_rreq = rreq1;
		next_wreq = wreq;
		entry.ren0 = rreq0.ren;
		entry.exp0 = exp0;
		entry.ren1 = rreq1.ren;
		entry.exp1 = exp1;
		expect_queue.push_back(entry);
	endtask

	task automatic drive_line(input int line);
		int base;
		bram_rreq_t rreq0;
		bram_rreq_t rreq1;
		bram_wreq_t wreq;
		base = line * FIELDS;
		rreq0.ren = pattern_mem[base][0];
		rreq0.rindex = pattern_mem[base + 1][INDEX_WIDTH-1:0];
		rreq1.ren = pattern_mem[base + 2][0];
		rreq1.rindex = pattern_mem[base + 3][INDEX_WIDTH-1:0];
		wreq.wen_byte = pattern_mem[base + 4][BYTE_LANES-1:0];
		wreq.windex = pattern_mem[base + 5][INDEX_WIDTH-1:0];
		wreq.wdata = pattern_mem[base + 6];
		apply_request(rreq0, rreq1, wreq, pattern_mem[base + 7], pattern_mem[base + 8]);
	endtask

	// compares the line that was driven PIPE_DEPTH edges ago.
	// a port whose read enable was low holds its word and is not checked.
	task automatic check_oldest();
		expected_t oldest;
		if (expect_queue.size() >= PIPE_DEPTH) begin
			oldest = expect_queue.pop_front();
			if (oldest.ren0) begin
				compare_word("last_port0_rdata", last_port0_rdata, oldest.exp0);
			end
			if (oldest.ren1) begin
				compare_word("last_port1_rdata", last_port1_rdata, oldest.exp1);
			end
		end
	endtask

	initial begin : watchdog
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("timeout: the run did not end within %0d cycles", cycle_limit);
		error_count++;
		finish_run();
	end

	initial begin : stimulus
		CLK = 1'b0;
		nRST = 1'b0;
		next_port0_rreq = '0;
		next_port1_rreq = '0;
		next_wreq = '0;
		error_count = 0;
		check_count = 0;

		load_patterns();
		if (line_count == 0) begin
			$display("no pattern lines could be read from %s", PATTERN_FILE);
			error_count++;
		end
		cycle_limit = line_count + RESET_CYCLES + TIMEOUT_MARGIN;

		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		nRST = 1'b1;

		// each cycle checks the line driven three edges earlier and then drives the next one.
		for (int line = 0; line < line_count; line++) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			check_oldest();
			drive_line(line);
		end

		// idle cycles push the last reads through the pipeline.
		repeat (PIPE_DEPTH) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			check_oldest();
			apply_request('0, '0, '0, '0, '0);
		end

		finish_run();
	end

endmodule

// File: bram_patterns.txt
// columns: p0_ren p0_idx p1_ren p1_idx wen_byte widx wdata exp0 exp1 (all hex)
// a read sees every write from earlier lines but not the write on its own line.
// reset contents, nothing written yet.
1 00 1 1f 0 00 00000000 00000000 00000000
1 05 1 0a 0 00 00000000 00000000 00000000
1 13 1 1e 0 00 00000000 00000000 00000000
1 07 1 07 0 00 00000000 00000000 00000000
1 11 1 12 0 00 00000000 00000000 00000000
1 1c 1 0e 0 00 00000000 00000000 00000000
1 09 1 0b 0 00 00000000 00000000 00000000
1 17 1 1a 0 00 00000000 00000000 00000000
// full word writes.
0 00 0 00 f 01 11111111 00000000 00000000
0 00 0 00 f 02 22222222 00000000 00000000
0 00 0 00 f 03 33333333 00000000 00000000
0 00 0 00 f 04 44444444 00000000 00000000
0 00 0 00 f 10 a5a5a5a5 00000000 00000000
0 00 0 00 f 1f deadbeef 00000000 00000000
0 00 0 00 f 08 0badf00d 00000000 00000000
0 00 0 00 f 15 12345678 00000000 00000000
// read back on port 0, then on port 1, then on both.
1 01 0 00 0 00 00000000 11111111 00000000
1 02 0 00 0 00 00000000 22222222 00000000
1 03 0 00 0 00 00000000 33333333 00000000
1 04 0 00 0 00 00000000 44444444 00000000
0 00 1 10 0 00 00000000 00000000 a5a5a5a5
0 00 1 1f 0 00 00000000 00000000 deadbeef
0 00 1 08 0 00 00000000 00000000 0badf00d
0 00 1 15 0 00 00000000 00000000 12345678
1 10 1 01 0 00 00000000 a5a5a5a5 11111111
1 1f 1 15 0 00 00000000 deadbeef 12345678
// single byte lanes.
0 00 0 00 1 01 aabbccdd 00000000 00000000
0 00 0 00 2 02 aabbccdd 00000000 00000000
0 00 0 00 4 03 aabbccdd 00000000 00000000
0 00 0 00 8 04 aabbccdd 00000000 00000000
1 01 1 02 0 00 00000000 111111dd 2222cc22
1 03 1 04 0 00 00000000 33bb3333 aa444444
// mixed lanes, and a write with no lane enabled that must change nothing.
0 00 0 00 5 10 01020304 00000000 00000000
0 00 0 00 a 1f 01020304 00000000 00000000
0 00 0 00 3 08 ffffeeee 00000000 00000000
0 00 0 00 c 15 9abcdef0 00000000 00000000
0 00 0 00 e 05 87654321 00000000 00000000
0 00 0 00 0 01 ffffffff 00000000 00000000
1 10 1 1f 0 00 00000000 a502a504 01ad03ef
1 08 1 15 0 00 00000000 0badeeee 9abc5678
1 05 1 01 0 00 00000000 87654300 111111dd
// two partial writes in a row to one entry.
0 00 0 00 1 05 000000ff 00000000 00000000
0 00 0 00 8 05 11000000 00000000 00000000
1 05 0 00 0 00 00000000 116543ff 00000000
// both ports at once, same index and different indices.
1 03 1 03 0 00 00000000 33bb3333 33bb3333
1 02 1 04 0 00 00000000 2222cc22 aa444444
1 04 1 02 0 00 00000000 aa444444 2222cc22
0 00 1 08 0 00 00000000 00000000 0badeeee
1 15 0 00 0 00 00000000 9abc5678 00000000
1 1f 1 10 0 00 00000000 01ad03ef a502a504
// read and write of one index on one line return the old word.
1 02 1 02 f 02 cafef00d 2222cc22 2222cc22
1 02 1 02 0 00 00000000 cafef00d cafef00d
1 03 0 00 1 03 00000077 33bb3333 00000000
0 00 1 03 0 00 00000000 00000000 33bb3377
1 06 0 00 f 06 5a5a5a5a 00000000 00000000
1 06 1 06 0 00 00000000 5a5a5a5a 5a5a5a5a
1 04 1 01 6 01 00abcd00 aa444444 111111dd
0 00 1 01 0 00 00000000 00000000 11abcddd
// back to back reads with writes landing between them.
1 18 1 19 f 18 00000018 00000000 00000000
1 18 1 19 f 19 00000019 00000018 00000000
1 19 1 18 f 1a 0000001a 00000019 00000018
1 1a 1 1b f 1b 0000001b 0000001a 00000000
1 1b 1 1a 8 18 ff000000 0000001b 0000001a
1 18 1 18 0 00 00000000 ff000018 ff000018
1 01 1 10 0 00 00000000 11abcddd a502a504
1 1f 1 05 0 00 00000000 01ad03ef 116543ff
1 02 1 03 0 00 00000000 cafef00d 33bb3377
1 06 1 15 0 00 00000000 5a5a5a5a 9abc5678
1 08 1 04 f 08 76543210 0badeeee aa444444
1 08 1 08 0 00 00000000 76543210 76543210
// one lane per cycle into entry 0c while it is read every cycle.
1 0c 1 0d 1 0c 000000a1 00000000 00000000
1 0c 1 0d 2 0c 0000b200 000000a1 00000000
1 0c 1 0c 4 0c 00c30000 0000b2a1 0000b2a1
1 0c 0 00 8 0c d4000000 00c3b2a1 00000000
1 0c 1 0c 9 0c ff0000ff d4c3b2a1 d4c3b2a1
1 0c 1 0d f 0d 0c0c0c0c ffc3b2ff 00000000
1 0d 1 0c 0 00 00000000 0c0c0c0c ffc3b2ff
1 0d 1 0d 6 0d 00ffff00 0c0c0c0c 0c0c0c0c
1 0d 0 00 0 00 00000000 0cffff0c 00000000
// stream through every written entry.
1 01 1 02 0 00 00000000 11abcddd cafef00d
1 03 1 04 0 00 00000000 33bb3377 aa444444
1 05 1 06 0 00 00000000 116543ff 5a5a5a5a
1 08 1 0c 0 00 00000000 76543210 ffc3b2ff
1 0d 1 10 0 00 00000000 0cffff0c a502a504
1 15 1 18 0 00 00000000 9abc5678 ff000018
1 19 1 1a 0 00 00000000 00000019 0000001a
1 1b 1 1f 0 00 00000000 0000001b 01ad03ef
1 0e 1 1d 0 00 00000000 00000000 00000000
// idle.
0 00 0 00 0 00 00000000 00000000 00000000
0 00 0 00 0 00 00000000 00000000 00000000

// File: list.f
core_types_pkg.sv
bram_port_pkg.sv
bram_2rport_1wport.sv
bram_2rport_1wport_wrapper.sv
tb_bram_2rport_1wport.sv

// File: Makefile
# Verilator build and run for the dual-read BRAM wrapper testbench.

VERILATOR ?= verilator
TOP ?= tb_bram_2rport_1wport
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= Test OK

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only when the pass line shows up in the output.
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
